// File: design/nes_video_pkg.sv
// NES video package
// Host write opcodes and video standard type

package nes_video_pkg;

	// Host write opcodes
	typedef enum logic [1:0] {
		OP_CTRL  = 2'd0, // Control register
		OP_PAL_A = 2'd1, // Palette set A entry
		OP_PAL_B = 2'd2  // Palette set B entry
	} cfg_op_t;

	// Video standard, also the frame length selector
	typedef enum logic {
		STD_NTSC = 1'b0,
		STD_PAL  = 1'b1
	} video_std_t;

endpackage

// File: design/nes_video_top.sv
// NES video output stage
// Palette lookup, raster timing, blanking and sync around a host config block
`timescale 1ns/1ps

module nes_video_top
	import nes_video_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic [5:0]  color,
	input  logic [8:0]  count_v,
	input  logic        cfg_we,
	input  cfg_op_t     cfg_op,
	input  logic [5:0]  cfg_index,
	input  logic [15:0] cfg_data,
	output logic        sync_h,
	output logic        sync_v,
	output logic [4:0]  r,
	output logic [4:0]  g,
	output logic [4:0]  b
);

	video_std_t  std;
	logic        overscan;
	logic        pal_sel;
	logic        pal_we_a;
	logic        pal_we_b;
	logic [5:0]  pal_waddr;
	logic [14:0] pal_wdata;
	logic [14:0] pixel;
	logic [9:0]  h;
	logic [9:0]  v;

	video_cfg_regs i_video_cfg_regs (
		.clk       (clk),
		.reset     (reset),
		.cfg_we    (cfg_we),
		.cfg_op    (cfg_op),
		.cfg_index (cfg_index),
		.cfg_data  (cfg_data),
		.std       (std),
		.overscan  (overscan),
		.pal_sel   (pal_sel),
		.pal_we_a  (pal_we_a),
		.pal_we_b  (pal_we_b),
		.pal_waddr (pal_waddr),
		.pal_wdata (pal_wdata)
	);

	palette_lut i_palette_lut (
		.clk       (clk),
		.pal_we_a  (pal_we_a),
		.pal_we_b  (pal_we_b),
		.pal_waddr (pal_waddr),
		.pal_wdata (pal_wdata),
		.color     (color),
		.pal_sel   (pal_sel),
		.pixel     (pixel)
	);

	video_timing i_video_timing (
		.clk     (clk),
		.reset   (reset),
		.count_v (count_v),
		.std     (std),
		.pix_en  (),
		.h       (h),
		.v       (v),
		.sync_h  (sync_h),
		.sync_v  (sync_v)
	);

	// h and v hold for the disabled cycle, so every clock carries a pixel
	pixel_shaper i_pixel_shaper (
		.clk      (clk),
		.reset    (reset),
		.h        (h),
		.v        (v),
		.overscan (overscan),
		.pixel    (pixel),
		.r        (r),
		.g        (g),
		.b        (b)
	);

endmodule

// File: design/palette_lut.sv
// Palette lookup
// Two host-writable 64x15 palette sets with a registered selectable read
`timescale 1ns/1ps

module palette_lut (
	input  logic        clk,
	input  logic        pal_we_a,
	input  logic        pal_we_b,
	input  logic [5:0]  pal_waddr,
	input  logic [14:0] pal_wdata,
	input  logic [5:0]  color,
	input  logic        pal_sel,
	output logic [14:0] pixel
);

	// Set 0 is palette A, set 1 is palette B
	logic [14:0] mem [0:1][0:63];
	logic [1:0]  set_we;
	logic [14:0] rd_a;
	logic [14:0] rd_b;

	assign set_we = {pal_we_b, pal_we_a};

	initial begin
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < 64; i++) begin
				mem[s][i] = 15'd0;
			end
		end
	end

	// One write port per set
	for (genvar s = 0; s < 2; s++) begin : g_set
		always_ff @(posedge clk) begin
			if (set_we[s]) begin
				mem[s][pal_waddr] <= pal_wdata;
			end
		end
	end

	// Both sets read at color every clock
	assign rd_a = mem[0][color];
	assign rd_b = mem[1][color];

	// Selected set registered, same-entry write returns the old value
	always_ff @(posedge clk) begin
		pixel <= pal_sel ? rd_b : rd_a;
	end

endmodule

// File: design/pixel_shaper.sv
// Pixel shaper
// Lines up raster position with the palette output, then blanks and overlays
`timescale 1ns/1ps
`include "nes_video_consts.svh"

module pixel_shaper (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`RASTER_W-1:0] h,
	input  logic [`RASTER_W-1:0] v,
	input  logic                 overscan,
	input  logic [14:0]          pixel,
	output logic [4:0]           r,
	output logic [4:0]           g,
	output logic [4:0]           b
);

	logic visible;
	logic overlay;
	logic visible_d;
	logic overlay_d;

	assign visible = (h < `RASTER_W'(`H_PICTURE)) && (v < `RASTER_W'(`V_PICTURE));

	// Border band that hides overscan garbage
	assign overlay = overscan && ((h > `RASTER_W'(`OS_RIGHT)) ||
		(h < `RASTER_W'(`OS_LEFT)) ||
		(v < `RASTER_W'(`OS_TOP)) ||
		(v > `RASTER_W'(`OS_BOTTOM)));

	// Decisions delayed one clock to match the palette read
	always_ff @(posedge clk) begin
		if (reset) begin
			visible_d <= 1'b0;
			overlay_d <= 1'b0;
		end else begin
			visible_d <= visible;
			overlay_d <= overlay;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r <= 5'd0;
			g <= 5'd0;
			b <= 5'd0;
		end else if (!visible_d) begin
			r <= 5'd0; // Blanked
			g <= 5'd0;
			b <= 5'd0;
		end else if (overlay_d) begin
			// Only the top bit of each channel survives, moved to bit 0
			r <= {4'd0, pixel[4]};
			g <= {4'd0, pixel[9]};
			b <= {4'd0, pixel[14]};
		end else begin
			r <= pixel[4:0];
			g <= pixel[9:5];
			b <= pixel[14:10];
		end
	end

endmodule

// File: design/video_cfg_regs.sv
// Video configuration registers
// Decodes host writes into the control register and palette write strobes
`timescale 1ns/1ps

module video_cfg_regs
	import nes_video_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        cfg_we,
	input  cfg_op_t     cfg_op,
	input  logic [5:0]  cfg_index,
	input  logic [15:0] cfg_data,
	output video_std_t  std,
	output logic        overscan,
	output logic        pal_sel,
	output logic        pal_we_a,
	output logic        pal_we_b,
	output logic [5:0]  pal_waddr,
	output logic [14:0] pal_wdata
);

	logic ctrl_we;

	assign ctrl_we = cfg_we && (cfg_op == OP_CTRL);

	// Control register, NTSC with overscan off and set A after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			std      <= STD_NTSC;
			overscan <= 1'b0;
			pal_sel  <= 1'b0;
		end else if (ctrl_we) begin
			std      <= video_std_t'(cfg_data[0]); // 1 = PAL
			overscan <= cfg_data[1];
			pal_sel  <= cfg_data[2]; // 1 = set B
		end
	end

	// Palette writes go straight through as single cycle strobes
	assign pal_we_a  = cfg_we && (cfg_op == OP_PAL_A);
	assign pal_we_b  = cfg_we && (cfg_op == OP_PAL_B);
	assign pal_waddr = cfg_index;
	assign pal_wdata = cfg_data[14:0]; // 5:5:5 entry, bit 15 unused

	// Host must never issue the spare opcode
	a_known_op: assert property (
		@(posedge clk) disable iff (reset)
		cfg_we |-> (cfg_op inside {OP_CTRL, OP_PAL_A, OP_PAL_B})
	) else $error("video_cfg_regs: unknown opcode %0h", cfg_op);

endmodule

// File: design/video_timing.sv
// Video raster timing
// Half-rate pixel enable, raster counters with frame resync and sync pulses
`timescale 1ns/1ps
`include "nes_video_consts.svh"

module video_timing
	import nes_video_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic [8:0]           count_v,
	input  video_std_t           std,
	output logic                 pix_en,
	output logic [`RASTER_W-1:0] h,
	output logic [`RASTER_W-1:0] v,
	output logic                 sync_h,
	output logic                 sync_v
);

	logic [8:0]           old_count_v;
	logic                 sync_frame;
	logic                 h_end;
	logic                 v_end;
	logic [`RASTER_W-1:0] v_last;
	logic [`RASTER_W-1:0] vsync_first;
	logic                 in_vsync;

	// Frame length and vsync line follow the standard
	assign v_last      = (std == STD_PAL) ? `RASTER_W'(`V_LAST_PAL) : `RASTER_W'(`V_LAST_NTSC);
	assign vsync_first = (std == STD_PAL) ? `RASTER_W'(`VSYNC_PAL) : `RASTER_W'(`VSYNC_NTSC);

	assign h_end    = (h == `RASTER_W'(`H_LAST));
	assign v_end    = (v == v_last);
	assign in_vsync = (v >= vsync_first) && (v < vsync_first + `RASTER_W'(`VSYNC_LINES));

	// Picture unit line counter wrapped 511 -> 0
	assign sync_frame = (old_count_v == 9'd511) && (count_v == 9'd0);

	// Low for one cycle out of reset, then every other clock
	always_ff @(posedge clk) begin
		if (reset) begin
			pix_en <= 1'b0;
		end else begin
			pix_en <= ~pix_en;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			h           <= '0;
			v           <= '0;
			old_count_v <= 9'd0;
		end else if (pix_en) begin
			old_count_v <= count_v; // Sampled on enabled cycles only
			if (sync_frame) begin
				h <= '0;
				v <= '0;
			end else if (h_end) begin
				h <= '0;
				v <= v_end ? '0 : v + 1'b1;
			end else begin
				h <= h + 1'b1;
			end
		end
	end

	// Sync pulses, a resync also ends a running hsync
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_h <= 1'b0;
			sync_v <= 1'b0;
		end else if (pix_en) begin
			if (sync_frame) begin
				sync_h <= 1'b0;
			end else if (h == `RASTER_W'(`HSYNC_START)) begin
				sync_h <= 1'b1;
				sync_v <= in_vsync; // Vsync only changes at hsync start
			end else if (h == `RASTER_W'(`HSYNC_END)) begin
				sync_h <= 1'b0;
			end
		end
	end

	a_h_range: assert property (
		@(posedge clk) disable iff (reset) h <= `RASTER_W'(`H_LAST)
	) else $error("video_timing: h out of range %0d", h);

	a_v_range: assert property (
		@(posedge clk) disable iff (reset) v <= `RASTER_W'(`V_LAST_PAL)
	) else $error("video_timing: v out of range %0d", v);

	// Hsync stays in the blanking part of the line
	a_hsync_blank: assert property (
		@(posedge clk) disable iff (reset) sync_h |-> (h >= `RASTER_W'(`H_PICTURE))
	) else $error("video_timing: sync_h inside picture at h %0d", h);

endmodule

// File: include/nes_video_consts.svh
// NES video output constants
// Raster geometry, sync positions and overscan margins in half-rate pixels
`ifndef NES_VIDEO_CONSTS_SVH
`define NES_VIDEO_CONSTS_SVH

// Raster counter width
`define RASTER_W 10

// Horizontal geometry
`define H_PICTURE 512
`define H_LAST 681 // 682 pixels per line

// Vertical geometry
`define V_PICTURE 240
`define V_LAST_NTSC 261 // 262 lines
`define V_LAST_PAL 311 // 312 lines

// Sync positions
`define HSYNC_START 556
`define HSYNC_END 606
`define VSYNC_NTSC 243
`define VSYNC_PAL 270
`define VSYNC_LINES 3

// Overlay border that hides the overscan area
`define OS_LEFT 20
`define OS_RIGHT 496
`define OS_TOP 6
`define OS_BOTTOM 230

`endif

// File: run_sim.sh
#!/bin/sh
# Builds the NES video testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module tb_nes_video -o sim_nes_video

sim_out=$(./obj_dir/sim_nes_video 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1

// File: tb.f
+incdir+include
design/nes_video_pkg.sv
design/video_cfg_regs.sv
design/palette_lut.sv
design/video_timing.sv
design/pixel_shaper.sv
design/nes_video_top.sv
testbench/tb_nes_video.sv

// File: testbench/tb_nes_video.sv
// NES video output stage testbench
// Random pixels and host writes checked against a cycle model of palette, raster and sync
`timescale 1ns/1ps
`include "nes_video_consts.svh"

module tb_nes_video
	import nes_video_pkg::*;
();

	localparam int CLOCKS_PER_LINE = 2 * (`H_LAST + 1);
	// Two NTSC vsync rises, one full PAL frame and the resync, with margin
	localparam int CYCLE_LIMIT = 1200000;

	logic        clk;
	logic        reset;
	logic [5:0]  color;
	logic [8:0]  count_v;
	logic        cfg_we;
	cfg_op_t     cfg_op;
	logic [5:0]  cfg_index;
	logic [15:0] cfg_data;
	logic        sync_h;
	logic        sync_v;
	logic [4:0]  r;
	logic [4:0]  g;
	logic [4:0]  b;

	// Input values for the coming rising edge
	logic        nxt_reset;
	logic [5:0]  nxt_color;
	logic [8:0]  nxt_count_v;
	logic        nxt_we;
	cfg_op_t     nxt_op;
	logic [5:0]  nxt_index;
	logic [15:0] nxt_data;
	logic        want_pal; // Standard the stimulus keeps in control writes

	// Reference model
	logic [14:0] m_pal [0:1][0:63];
	logic        m_std;
	logic        m_os;
	logic        m_sel;
	logic        m_en;
	logic        m_sync_h;
	logic        m_sync_v;
	logic [9:0]  m_h;
	logic [9:0]  m_v;
	logic [8:0]  m_old_cv;
	logic [14:0] exp_q [$]; // Expected {b, g, r} in flight
	logic [14:0] exp_rgb;

	integer seed;
	int     cycle;
	int     last_vrise;
	bit     period_valid;
	int     ntsc_frames;
	int     pal_frames;
	int     resync_cycle;
	bit     resync_pending;
	int     resync_checks;
	logic   last_sync_h;
	logic   last_sync_v;

	nes_video_top i_nes_video_top (
		.clk       (clk),
		.reset     (reset),
		.color     (color),
		.count_v   (count_v),
		.cfg_we    (cfg_we),
		.cfg_op    (cfg_op),
		.cfg_index (cfg_index),
		.cfg_data  (cfg_data),
		.sync_h    (sync_h),
		.sync_v    (sync_v),
		.r         (r),
		.g         (g),
		.b         (b)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual == expected)
		else fail_stop($sformatf("** Error: %s expected 0x%0h actual 0x%0h",
			name, expected, actual));
	endtask

	function automatic logic [9:0] last_line(input logic pal);
		last_line = pal ? 10'(`V_LAST_PAL) : 10'(`V_LAST_NTSC);
	endfunction

	function automatic logic [9:0] first_vsync_line(input logic pal);
		first_vsync_line = pal ? 10'(`VSYNC_PAL) : 10'(`VSYNC_NTSC);
	endfunction

	// Result packed as {b, g, r}
	function automatic logic [14:0] shape_pixel(input logic [14:0] pix,
		input logic [9:0] hpos, input logic [9:0] vpos, input logic os);
		logic border;
		border = os && (hpos > `OS_RIGHT || hpos < `OS_LEFT ||
			vpos < `OS_TOP || vpos > `OS_BOTTOM);
		if (hpos >= `H_PICTURE || vpos >= `V_PICTURE) begin
			shape_pixel = 15'd0;
		end else if (border) begin
			shape_pixel = {4'd0, pix[14], 4'd0, pix[9], 4'd0, pix[4]};
		end else begin
			shape_pixel = pix;
		end
	endfunction

	// One rising edge of the model, all decisions from the values before the edge
	task automatic model_edge;
		logic [14:0] rd;
		logic [9:0]  vs_first;
		logic        restart;
		cycle++;
		if (reset) begin
			m_en     = 1'b0;
			m_h      = '0;
			m_v      = '0;
			m_old_cv = '0;
			m_sync_h = 1'b0;
			m_sync_v = 1'b0;
			m_std    = 1'b0;
			m_os     = 1'b0;
			m_sel    = 1'b0;
			exp_rgb  = '0;
			exp_q.delete();
		end else begin
			rd = m_pal[m_sel][color];
			exp_q.push_back(shape_pixel(rd, m_h, m_v, m_os));
			if (exp_q.size() > 1) exp_rgb = exp_q.pop_front(); // Two clocks from color
			if (m_en) begin
				restart  = (m_old_cv == 9'd511) && (count_v == 9'd0);
				m_old_cv = count_v;
				vs_first = first_vsync_line(m_std);
				if (restart) begin
					m_sync_h       = 1'b0;
					resync_cycle   = cycle;
					resync_pending = 1'b1;
					period_valid   = 1'b0;
				end else if (m_h == `HSYNC_START) begin
					m_sync_h = 1'b1;
					m_sync_v = (m_v >= vs_first) && (m_v < vs_first + `VSYNC_LINES);
				end else if (m_h == `HSYNC_END) begin
					m_sync_h = 1'b0;
				end
				if (restart) begin
					m_h = '0;
					m_v = '0;
				end else if (m_h == `H_LAST) begin
					m_h = '0;
					m_v = (m_v == last_line(m_std)) ? 10'd0 : m_v + 10'd1;
				end else begin
					m_h = m_h + 10'd1;
				end
			end
			m_en = !m_en;
			if (cfg_we && cfg_op == OP_CTRL) begin
				if (cfg_data[0] != m_std) period_valid = 1'b0; // Frame length changes
				m_std = cfg_data[0];
				m_os  = cfg_data[1];
				m_sel = cfg_data[2];
			end
		end
		if (cfg_we && cfg_op == OP_PAL_A) m_pal[0][cfg_index] = cfg_data[14:0];
		if (cfg_we && cfg_op == OP_PAL_B) m_pal[1][cfg_index] = cfg_data[14:0];
	endtask

	task automatic check_outputs;
		check_value("sync_h", m_sync_h, sync_h);
		check_value("sync_v", m_sync_v, sync_v);
		check_value("r", exp_rgb[4:0], r);
		check_value("g", exp_rgb[9:5], g);
		check_value("b", exp_rgb[14:10], b);
		if (sync_v && !last_sync_v) begin
			if (period_valid) begin
				check_value("sync_v period", CLOCKS_PER_LINE * (last_line(m_std) + 1),
					cycle - last_vrise);
				if (m_std) pal_frames++;
				else ntsc_frames++;
			end
			last_vrise   = cycle;
			period_valid = 1'b1;
		end
		if (sync_h && !last_sync_h && resync_pending) begin
			// h counts 0 through HSYNC_START after the restart, two clocks per pixel
			check_value("sync_h after resync", 2 * (`HSYNC_START + 1), cycle - resync_cycle);
			resync_pending = 1'b0;
			resync_checks++;
		end
		last_sync_h = sync_h;
		last_sync_v = sync_v;
	endtask

	task automatic run_cycle;
		@(posedge clk);
		model_edge();
		reset     <= nxt_reset;
		color     <= nxt_color;
		count_v   <= nxt_count_v;
		cfg_we    <= nxt_we;
		cfg_op    <= nxt_op;
		cfg_index <= nxt_index;
		cfg_data  <= nxt_data;
		@(negedge clk); // Outputs settled
		check_outputs();
	endtask

	task automatic host_write(input cfg_op_t op, input logic [5:0] index,
		input logic [15:0] data);
		nxt_we    = 1'b1;
		nxt_op    = op;
		nxt_index = index;
		nxt_data  = data;
		run_cycle();
		nxt_we = 1'b0;
	endtask

	// Random overscan and set select, standard held
	task automatic write_ctrl(input logic [31:0] rnd);
		host_write(OP_CTRL, rnd[21:16], {rnd[31:19], rnd[2], rnd[1], want_pal});
	endtask

	task automatic random_cycle;
		logic [31:0] rnd;
		logic [31:0] wdata;
		rnd       = $random(seed);
		wdata     = $random(seed);
		nxt_color = rnd[5:0];
		if (rnd[15:8] == 8'd0) begin
			write_ctrl(wdata);
		end else if (rnd[15:8] == 8'd1) begin
			host_write(rnd[16] ? OP_PAL_B : OP_PAL_A, rnd[22:17], wdata[15:0]);
		end else begin
			run_cycle();
		end
	endtask

	// Watchdog
	initial begin
		while (cycle < CYCLE_LIMIT) @(posedge clk);
		fail_stop("Simulation timeout, the test sequence did not finish");
	end

	initial begin
		logic [31:0] rnd;
		int          wait_len;
		seed = 32'h3987_7390;
		for (int s = 0; s < 2; s++) begin
			for (int i = 0; i < 64; i++) m_pal[s][i] = 15'd0;
		end
		cycle = 0;
		last_vrise = 0;
		period_valid = 1'b0;
		ntsc_frames = 0;
		pal_frames = 0;
		resync_cycle = 0;
		resync_pending = 1'b0;
		resync_checks = 0;
		last_sync_h = 1'b0;
		last_sync_v = 1'b0;
		want_pal = 1'b0;
		reset = 1'b1;
		color = '0;
		count_v = '0;
		cfg_we = 1'b0;
		cfg_op = OP_CTRL;
		cfg_index = '0;
		cfg_data = '0;
		nxt_reset = 1'b1;
		nxt_color = '0;
		nxt_count_v = '0;
		nxt_we = 1'b0;
		nxt_op = OP_CTRL;
		nxt_index = '0;
		nxt_data = '0;

		repeat (3) run_cycle();
		nxt_reset = 1'b0;
		run_cycle();

		// Fill both palette sets, bit 15 is random too
		for (int i = 0; i < 64; i++) begin
			rnd = $random(seed);
			host_write(OP_PAL_A, i[5:0], rnd[15:0]);
			rnd = $random(seed);
			host_write(OP_PAL_B, i[5:0], rnd[15:0]);
		end

		// NTSC until one full frame between vsync rises was measured
		while (ntsc_frames == 0) random_cycle();

		want_pal = 1'b1;
		rnd = $random(seed);
		write_ctrl(rnd);
		while (pal_frames == 0) random_cycle();

		// Line counter of the picture unit wraps at a random moment
		rnd = $random(seed);
		wait_len = int'(rnd[9:0]);
		repeat (wait_len) random_cycle();
		nxt_count_v = 9'd511;
		repeat (4) random_cycle();
		nxt_count_v = 9'd0;
		while (resync_checks == 0) random_cycle();
		repeat (200) random_cycle();

		$display("Test OK");
		$finish;
	end

endmodule
